/* sim_ram_consts.svh */
/* AXI4-Lite RAM model constants
   Bus widths, outstanding-request depth and LFSR start values */

`ifndef SIM_RAM_CONSTS_SVH
`define SIM_RAM_CONSTS_SVH

// Byte address and data widths
`define SIM_RAM_ADDR_W      8
`define SIM_RAM_DATA_W      32

// Entries per outstanding-request queue
`define SIM_RAM_OSTD_NUM    4

// LFSR start values, one per throttled channel, never zero
`define SIM_RAM_AR_SEED     32'hCCCC_CCCC
`define SIM_RAM_W_SEED      32'h8711_CBAA
`define SIM_RAM_R_SEED      32'h986A_23CC

`endif

/* axil_pkg.sv */
/* AXI4-Lite channel types
   Address, data, strobe and response fields of the slave port */

`include "sim_ram_consts.svh"

package axil_pkg;

    // Channel payload fields
    typedef logic [`SIM_RAM_ADDR_W-1:0]   addr_t;
    typedef logic [`SIM_RAM_DATA_W-1:0]   data_t;
    typedef logic [`SIM_RAM_DATA_W/8-1:0] strb_t;
    typedef logic [1:0]                   resp_t;

    // The model never reports an error
    localparam resp_t RESP_OKAY = 2'b00;

    // One write data beat as stored in the data queue
    typedef struct packed {
        data_t data;
        strb_t strb;
    } wbeat_t;

endpackage

/* ram_pkg.sv */
/* Memory array types
   Word index, array size and throttle LFSR state */

`include "sim_ram_consts.svh"

package ram_pkg;

    // Byte address bits below the word index
    localparam int BYTE_LSB_W = $clog2(`SIM_RAM_DATA_W / 8);

    // Word index, the byte address without its low bits
    localparam int WORD_IDX_W = `SIM_RAM_ADDR_W - BYTE_LSB_W;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    // Words in the array, one per index
    localparam int RAM_WORDS = 2 ** WORD_IDX_W;

    // Throttle LFSR and shift register state
    typedef logic [31:0] lfsr_t;

endpackage

/* mem_if.sv */
/* Array access port
   Joins the write and read access stages to the word storage */

`timescale 1ns/1ps

interface mem_if
    import axil_pkg::*, ram_pkg::*;
();

    // Write port, one word per cycle
    logic       we;
    word_idx_t  widx;
    data_t      wdata;
    strb_t      wstrb;

    // Combinational read port
    word_idx_t  ridx;
    data_t      rdata;

    modport writer (
        output we, widx, wdata, wstrb
    );

    modport reader (
        output ridx,
        input  rdata
    );

    modport array (
        input  we, widx, wdata, wstrb, ridx,
        output rdata
    );

endinterface

/* req_fifo.sv */
/* Outstanding-request queue
   Circular buffer holding one payload per accepted request */

`timescale 1ns/1ps

`include "sim_ram_consts.svh"

module req_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `SIM_RAM_OSTD_NUM
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pull,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    // Oldest entry sits at the read pointer
    assign pop_data = slots[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    // Upstream ready and downstream valid must follow the flags
    no_push_when_full: assert property (
        @(posedge aclk) disable iff (!aresetn) push |-> !full
    ) else $error("req_fifo: push while full");

    no_pull_when_empty: assert property (
        @(posedge aclk) disable iff (!aresetn) pull |-> !empty
    ) else $error("req_fifo: pull while empty");

endmodule

/* ready_throttle.sv */
/* Random channel throttle
   An LFSR feeds a shift register whose low bit grants the handshake */

`timescale 1ns/1ps

`include "sim_ram_consts.svh"

module ready_throttle
    import ram_pkg::*;
#(
    parameter lfsr_t SEED = `SIM_RAM_AR_SEED
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic handshake,
    output logic permit
);

    // Galois form of x^32 + x^22 + x^2 + x + 1
    localparam lfsr_t TAPS = 32'h8020_0003;

    lfsr_t lfsr;
    lfsr_t lfsr_next;
    lfsr_t shreg;

    assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? TAPS : '0);

    // One LFSR step per handshake
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lfsr <= SEED;
        end else if (handshake) begin
            lfsr <= lfsr_next;
        end
    end

    // A nonzero register shifted only while bit 0 is low stays nonzero
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            shreg <= '0;
        end else if (shreg == '0) begin
            shreg <= lfsr;
        end else if (handshake) begin
            shreg <= lfsr;
        end else if (!shreg[0]) begin
            shreg <= shreg >> 1;
        end
    end

    assign permit = shreg[0];

    // Bounds the stall to one register length
    shreg_reloads: assert property (
        @(posedge aclk) disable iff (!aresetn) (shreg == '0) |=> (shreg != '0)
    ) else $error("ready_throttle: shift register stuck at zero");

endmodule

/* ram_array.sv */
/* Word storage of the RAM model
   Byte-writable words with a combinational read port */

`timescale 1ns/1ps

module ram_array
    import axil_pkg::*, ram_pkg::*;
(
    input  logic  aclk,
    mem_if.array  mem
);

    localparam int BYTES = $bits(strb_t);

    // Contents start at zero
    data_t words [RAM_WORDS] = '{default: '0};

    ////////////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////////////

    // Only bytes with a high strobe change
    always_ff @(posedge aclk) begin
        if (mem.we) begin
            for (int i = 0; i < BYTES; i++) begin
                if (mem.wstrb[i]) begin
                    words[mem.widx][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////

    // A write at the same edge shows up from the next cycle
    assign mem.rdata = words[mem.ridx];

endmodule

/* write_stage.sv */
/* Write access stage
   Joins the queued address and data, writes the array, drives B */

`timescale 1ns/1ps

module write_stage
    import axil_pkg::*, ram_pkg::*;
(
    input  logic   aclk,
    input  logic   aresetn,
    input  addr_t  aw_addr,
    input  logic   aw_empty,
    input  wbeat_t w_beat,
    input  logic   w_empty,
    output logic   pull,
    output logic   bvalid,
    input  logic   bready,
    output resp_t  bresp,
    mem_if.writer  mem
);

    logic commit;

    // Both heads present and no response pending
    assign commit = !aw_empty && !w_empty && !bvalid;

    ////////////////////////////////////////////////////////////////////
    // Array write and queue pop
    ////////////////////////////////////////////////////////////////////

    assign mem.we    = commit;
    assign mem.widx  = aw_addr[BYTE_LSB_W +: $bits(word_idx_t)];
    assign mem.wdata = w_beat.data;
    assign mem.wstrb = w_beat.strb;

    // Both queues pop at the edge that writes the array
    assign pull = commit;

    ////////////////////////////////////////////////////////////////////
    // Write response
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            bvalid <= 1'b0;
        end else if (commit) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign bresp = RESP_OKAY;

    // AXI rule, a raised response waits for the master
    bvalid_holds: assert property (
        @(posedge aclk) disable iff (!aresetn) (bvalid && !bready) |=> bvalid
    ) else $error("write_stage: bvalid dropped before bready");

endmodule

/* read_stage.sv */
/* Read access stage
   Serves the oldest queued read and drives the R channel */

`timescale 1ns/1ps

module read_stage
    import axil_pkg::*, ram_pkg::*;
(
    input  addr_t  ar_addr,
    input  logic   ar_empty,
    input  logic   permit,
    output logic   rvalid,
    input  logic   rready,
    output logic   pull,
    output data_t  rdata,
    output resp_t  rresp,
    mem_if.reader  mem
);

    // Low address bits select a byte and are dropped
    assign mem.ridx = ar_addr[BYTE_LSB_W +: $bits(word_idx_t)];

    // The throttle holds permit until the handshake, so rvalid stays up
    assign rvalid = !ar_empty && permit;

    // Head leaves the queue on the R handshake
    assign pull = rvalid && rready;

    // Data comes straight from the array word
    assign rdata = mem.rdata;
    assign rresp = RESP_OKAY;

endmodule

/* sim_ram_top.sv */
/* AXI4-Lite RAM model, simulation only
   Queued requests, random back-pressure and a byte-writable array */

`timescale 1ns/1ps

`include "sim_ram_consts.svh"

module sim_ram_top
    import axil_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    // Write address channel
    input  logic  awvalid,
    output logic  awready,
    input  addr_t awaddr,
    // Write data channel
    input  logic  wvalid,
    output logic  wready,
    input  data_t wdata,
    input  strb_t wstrb,
    // Write response channel
    output logic  bvalid,
    input  logic  bready,
    output resp_t bresp,
    // Read address channel
    input  logic  arvalid,
    output logic  arready,
    input  addr_t araddr,
    // Read data channel
    output logic  rvalid,
    input  logic  rready,
    output data_t rdata,
    output resp_t rresp
);

    logic   ar_full;
    logic   ar_empty;
    logic   ar_permit;
    addr_t  ar_head;
    logic   r_pull;
    logic   r_permit;

    logic   aw_full;
    logic   aw_empty;
    addr_t  aw_head;
    logic   w_full;
    logic   w_empty;
    wbeat_t w_head;
    logic   wr_pull;
    logic   w_permit;

    mem_if mem_bus ();

    ////////////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////////////

    assign arready = ar_permit && !ar_full;

    ready_throttle #(.SEED(`SIM_RAM_AR_SEED)) ar_throttle (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .handshake (arvalid && arready),
        .permit    (ar_permit)
    );

    req_fifo #(.payload_t(addr_t), .DEPTH(`SIM_RAM_OSTD_NUM)) ar_queue (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .push      (arvalid && arready),
        .push_data (araddr),
        .full      (ar_full),
        .pull      (r_pull),
        .pop_data  (ar_head),
        .empty     (ar_empty)
    );

    ready_throttle #(.SEED(`SIM_RAM_R_SEED)) r_throttle (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .handshake (rvalid && rready),
        .permit    (r_permit)
    );

    read_stage u_read_stage (
        .ar_addr  (ar_head),
        .ar_empty (ar_empty),
        .permit   (r_permit),
        .rvalid   (rvalid),
        .rready   (rready),
        .pull     (r_pull),
        .rdata    (rdata),
        .rresp    (rresp),
        .mem      (mem_bus.reader)
    );

    ////////////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////////////

    // One ready for AW and W, so address and data enter together
    assign awready = w_permit && !aw_full && !w_full;
    assign wready  = awready;

    ready_throttle #(.SEED(`SIM_RAM_W_SEED)) w_throttle (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .handshake ((awvalid || wvalid) && awready),
        .permit    (w_permit)
    );

    req_fifo #(.payload_t(addr_t), .DEPTH(`SIM_RAM_OSTD_NUM)) aw_queue (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .push      (awvalid && awready),
        .push_data (awaddr),
        .full      (aw_full),
        .pull      (wr_pull),
        .pop_data  (aw_head),
        .empty     (aw_empty)
    );

    req_fifo #(.payload_t(wbeat_t), .DEPTH(`SIM_RAM_OSTD_NUM)) w_queue (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .push      (wvalid && wready),
        .push_data (wbeat_t'{data: wdata, strb: wstrb}),
        .full      (w_full),
        .pull      (wr_pull),
        .pop_data  (w_head),
        .empty     (w_empty)
    );

    write_stage u_write_stage (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .aw_addr  (aw_head),
        .aw_empty (aw_empty),
        .w_beat   (w_head),
        .w_empty  (w_empty),
        .pull     (wr_pull),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .mem      (mem_bus.writer)
    );

    // Storage shared by both paths
    ram_array u_ram_array (
        .aclk (aclk),
        .mem  (mem_bus.array)
    );

endmodule

/* tb_sim_ram.sv */
/* Testbench for the AXI4-Lite RAM model
   Random traffic from a fixed seed, checked against a reference memory */

`timescale 1ns/1ps

`include "sim_ram_consts.svh"

module tb_sim_ram
    import axil_pkg::*, ram_pkg::*;
();

    localparam int TIMEOUT      = 200;
    localparam int STALL_CYCLES = 40;
    localparam int MAX_ACCEPTED = `SIM_RAM_OSTD_NUM + 1;
    localparam int DRIVE_DELAY  = 2;

    logic  aclk;
    logic  aresetn;
    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;
    logic  bvalid;
    logic  bready;
    resp_t bresp;
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;

    // Reference memory and bookkeeping
    data_t       model_mem [RAM_WORDS];
    logic [31:0] rng_state;
    int          b_count;

    sim_ram_top u_dut (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // LCG stepped twice, only the high halves are used
    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        hi = rng_state[31:16];
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {hi, rng_state[31:16]};
    endfunction

    // Two low address bits pick a byte inside the word
    function automatic int word_of(input addr_t addr);
        return int'(addr) / 4;
    endfunction

    function automatic void apply_write(input addr_t addr, input data_t data, input strb_t strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                model_mem[word_of(addr)][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string test, input data_t expected, input data_t actual);
        word_ok: assert (actual === expected) else
            report_failure($sformatf("MISMATCH %s expected %h actual %h",
                                     test, expected, actual));
    endtask

    // Holds AW and W valid until taken or max_wait cycles pass
    task automatic offer_write(input addr_t addr, input data_t data, input strb_t strb,
                               input int max_wait, output bit taken);
        int waited;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        taken   = 1'b0;
        waited  = 0;
        while (!taken && waited < max_wait) begin
            @(negedge aclk);
            if (awready && wready) begin
                taken = 1'b1;
            end else begin
                waited++;
            end
        end
        @(posedge aclk);
        #DRIVE_DELAY;
        if (taken) begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
    endtask

    task automatic write_word(input string test, input addr_t addr, input data_t data,
                              input strb_t strb);
        int  start;
        int  waited;
        bit  taken;
        start = b_count;
        offer_write(addr, data, strb, TIMEOUT, taken);
        if (!taken) begin
            report_failure($sformatf("%s: write was never accepted", test));
        end
        apply_write(addr, data, strb);
        waited = 0;
        do begin
            @(posedge aclk);
            waited++;
            if (waited >= TIMEOUT) begin
                report_failure($sformatf("%s: no write response arrived", test));
            end
        end while (b_count == start);
        #DRIVE_DELAY;
    endtask

    task automatic issue_read(input string test, input addr_t addr);
        int waited;
        arvalid = 1'b1;
        araddr  = addr;
        waited  = 0;
        do begin
            @(negedge aclk);
            waited++;
            if (!arready && waited >= TIMEOUT) begin
                report_failure($sformatf("%s: read address was never accepted", test));
            end
        end while (!arready);
        @(posedge aclk);
        #DRIVE_DELAY;
        arvalid = 1'b0;
    endtask

    // Takes one R beat, with rready either held high or random
    task automatic collect_read(input string test, input bit random_ready, output data_t data);
        logic [31:0] r;
        bit          got;
        int          waited;
        got    = 1'b0;
        waited = 0;
        while (!got) begin
            r = rand32();
            rready = random_ready ? r[31] : 1'b1;
            @(negedge aclk);
            if (rvalid && rready) begin
                got  = 1'b1;
                data = rdata;
                resp_ok: assert (rresp === RESP_OKAY) else
                    report_failure($sformatf("MISMATCH %s rresp expected %0d actual %0d",
                                             test, RESP_OKAY, rresp));
            end else begin
                waited++;
                if (waited >= TIMEOUT) begin
                    report_failure($sformatf("%s: read data never came back", test));
                end
            end
            @(posedge aclk);
            #DRIVE_DELAY;
        end
        rready = 1'b0;
    endtask

    task automatic read_check(input string test, input addr_t addr, input bit random_ready);
        data_t got;
        issue_read(test, addr);
        collect_read(test, random_ready, got);
        check_word(test, model_mem[word_of(addr)], got);
    endtask

    // B handshake is decided at the falling edge before the transfer
    always @(negedge aclk) begin
        if (aresetn && bvalid && bready) begin
            b_count = b_count + 1;
            bresp_ok: assert (bresp === RESP_OKAY) else
                report_failure($sformatf("MISMATCH write_response expected %0d actual %0d",
                                         RESP_OKAY, bresp));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        addr_t       a;
        data_t       d;
        data_t       got;
        strb_t       s;
        logic [31:0] r;
        addr_t       seen [$];
        addr_t       bp_addrs [$];
        addr_t       batch [4];
        bit          taken;
        bit          stalled;
        int          accepted;
        int          b_start;
        int          waited;

        aresetn   = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b1;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        rng_state = 32'd22982;
        b_count   = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_mem[i] = '0;
        end

        repeat (8) @(posedge aclk);
        #DRIVE_DELAY;
        aresetn = 1'b1;
        @(posedge aclk);
        #DRIVE_DELAY;

        // Memory reads as zero out of reset
        repeat (8) begin
            r = rand32();
            read_check("reset_contents", r[31:24], 1'b0);
        end

        // Random writes, then read back every address
        for (int i = 0; i < 24; i++) begin
            r = rand32();
            a = r[31:24];
            s = r[3:0];
            d = rand32();
            write_word("random_writes", a, d, s);
            seen.push_back(a);
        end
        foreach (seen[i]) begin
            read_check("random_writes", seen[i], 1'b0);
        end

        // Four reads queued while rready is low come back in order
        foreach (batch[i]) begin
            r = rand32();
            batch[i] = seen[r[15:0] % seen.size()];
            issue_read("outstanding_reads", batch[i]);
        end
        foreach (batch[i]) begin
            collect_read("outstanding_reads", 1'b0, got);
            check_word("outstanding_reads", model_mem[word_of(batch[i])], got);
        end

        // Write back-pressure with bready held low
        bready   = 1'b0;
        b_start  = b_count;
        accepted = 0;
        stalled  = 1'b0;
        while (!stalled && accepted < 8) begin
            r = rand32();
            a = r[31:24];
            s = r[3:0];
            d = rand32();
            offer_write(a, d, s, STALL_CYCLES, taken);
            if (taken) begin
                apply_write(a, d, s);
                bp_addrs.push_back(a);
                accepted++;
            end else begin
                stalled = 1'b1;
            end
        end
        stall_seen: assert (stalled) else
            report_failure("back_pressure: awready never stayed low with bready held low");
        accept_limit: assert (accepted <= MAX_ACCEPTED) else
            report_failure($sformatf("MISMATCH back_pressure expected at most %0d actual %0d",
                                     MAX_ACCEPTED, accepted));

        // The write still offered goes through once responses drain
        bready = 1'b1;
        offer_write(a, d, s, TIMEOUT, taken);
        if (!taken) begin
            report_failure("back_pressure: pending write was never accepted");
        end
        apply_write(a, d, s);
        bp_addrs.push_back(a);
        accepted++;
        waited = 0;
        do begin
            @(posedge aclk);
            waited++;
            if (waited >= TIMEOUT) begin
                report_failure("back_pressure: write responses did not all arrive");
            end
        end while (b_count < b_start + accepted);
        repeat (5) @(posedge aclk);
        #DRIVE_DELAY;
        one_resp_each: assert (b_count == b_start + accepted) else
            report_failure($sformatf("MISMATCH back_pressure expected %0d actual %0d",
                                     accepted, b_count - b_start));
        foreach (bp_addrs[i]) begin
            read_check("back_pressure", bp_addrs[i], 1'b0);
            seen.push_back(bp_addrs[i]);
        end

        // Reads with rready toggling at random
        repeat (20) begin
            r = rand32();
            a = r[31] ? seen[r[15:0] % seen.size()] : r[23:16];
            read_check("random_read_stalls", a, 1'b1);
        end

        $display("test passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
axil_pkg.sv
ram_pkg.sv
mem_if.sv
req_fifo.sv
ready_throttle.sv
ram_array.sv
write_stage.sv
read_stage.sv
sim_ram_top.sv
tb_sim_ram.sv
